// File: hdl/snp_cfg_pkg.sv
package snp_cfg_pkg;

    // **************************************************
    // fabric geometry
    // **************************************************
    localparam int num_banks      = 4;
    localparam int bank_bits      = $clog2(num_banks);
    localparam int snrq_depth     = 4;    // pending snoop slots
    localparam int slot_bits      = $clog2(snrq_depth);

    // tag store shape, one store per bank
    localparam int lines_per_bank = 16;
    localparam int index_bits     = $clog2(lines_per_bank);
    localparam int line_addr_bits = 16;
    localparam int tag_bits       = line_addr_bits - bank_bits - index_bits;

    localparam int snp_tag_bits   = 6;
    localparam int ack_cnt_bits   = $clog2(num_banks + 1);    // must reach num_banks itself

endpackage

// File: hdl/snp_types_pkg.sv
package snp_types_pkg;

    import snp_cfg_pkg::*;

    // **************************************************
    // payload types
    // **************************************************

    // bank in the low bits, then index, tag on top
    typedef logic [line_addr_bits-1:0] line_addr_t;

    typedef logic [snp_tag_bits-1:0] snp_tag_t;

    // a forwarded snoop is named by its pending slot
    typedef logic [slot_bits-1:0] fwd_tag_t;

    typedef logic [ack_cnt_bits-1:0] ack_cnt_t;

    typedef logic [bank_bits-1:0] bank_sel_t;

    // **************************************************
    // bank pipeline
    // **************************************************

    // stage 2 either waits for work or sits on an ack until the forwarder takes it
    typedef enum logic {
        idle,
        hold_ack
    } lookup_state_e;

endpackage

// File: hdl/snp_fwd_if.sv
`timescale 1ns/1ps

interface snp_fwd_if import snp_types_pkg::*; ();

    // broadcast snoop, forwarder to bank
    logic       fwd_valid;
    line_addr_t fwd_addr;
    fwd_tag_t   fwd_tag;
    logic       fwd_ready;

    // acknowledgement back to the forwarder
    logic       ack_valid;
    logic       ack_hit;
    fwd_tag_t   ack_tag;
    logic       ack_ready;

    modport forwarder (
        output fwd_valid, fwd_addr, fwd_tag, ack_ready,
        input  fwd_ready, ack_valid, ack_hit, ack_tag
    );

    modport bank (
        input  fwd_valid, fwd_addr, fwd_tag, ack_ready,
        output fwd_ready, ack_valid, ack_hit, ack_tag
    );

endinterface

// File: hdl/snp_bank_tags.sv
`timescale 1ns/1ps

module snp_bank_tags import snp_cfg_pkg::*, snp_types_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       fill_valid,
    input  line_addr_t fill_addr,

    snp_fwd_if.bank    bank,

    output logic       active
);

    // **************************************************
    // tag store
    // **************************************************
    logic [lines_per_bank-1:0] line_valid;
    logic [tag_bits-1:0]       line_tag [lines_per_bank];

    logic [index_bits-1:0]     fill_index;
    logic [tag_bits-1:0]       fill_tag;
    logic [index_bits-1:0]     snp_index;
    logic [tag_bits-1:0]       snp_tag;

    // stage 1 holds the entry as read at accept
    logic                      s1_valid;
    fwd_tag_t                  s1_fwd_tag;
    logic [index_bits-1:0]     s1_index;
    logic [tag_bits-1:0]       s1_tag;
    logic                      s1_entry_valid;
    logic [tag_bits-1:0]       s1_entry_tag;
    logic                      s1_hit;
    logic                      s1_advance;

    lookup_state_e             state;
    logic                      s2_hit;
    fwd_tag_t                  s2_fwd_tag;

    logic                      snp_accept;
    logic                      ack_take;

    // bank bits are the top level's business
    assign fill_index = fill_addr[bank_bits +: index_bits];
    assign fill_tag   = fill_addr[line_addr_bits-1 -: tag_bits];
    assign snp_index  = bank.fwd_addr[bank_bits +: index_bits];
    assign snp_tag    = bank.fwd_addr[line_addr_bits-1 -: tag_bits];

    assign bank.fwd_ready = !(s1_valid && state == hold_ack);
    assign snp_accept     = bank.fwd_valid && bank.fwd_ready;
    assign ack_take       = (state == hold_ack) && bank.ack_ready;
    assign s1_advance     = s1_valid && (state == idle || ack_take);
    assign s1_hit         = s1_entry_valid && (s1_entry_tag == s1_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (fill_valid) begin
                line_valid[fill_index] <= 1'b1;
            end
            if (s1_advance && s1_hit) begin
                line_valid[s1_index] <= 1'b0;    // write-through, so a snoop hit just drops the line
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            line_tag[fill_index] <= fill_tag;
        end
    end

    // **************************************************
    // snoop pipeline
    // **************************************************
    always_ff @(posedge clk) begin
        if (snp_accept) begin
            s1_fwd_tag     <= bank.fwd_tag;
            s1_index       <= snp_index;
            s1_tag         <= snp_tag;
            s1_entry_tag   <= line_tag[snp_index];
            // an invalidate landing on the same edge must not be missed
            s1_entry_valid <= line_valid[snp_index]
                              && !(s1_advance && s1_hit && s1_index == snp_index);
        end
        if (s1_advance) begin
            s2_hit     <= s1_hit;
            s2_fwd_tag <= s1_fwd_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            state    <= idle;
        end else begin
            if (snp_accept) begin
                s1_valid <= 1'b1;
            end else if (s1_advance) begin
                s1_valid <= 1'b0;
            end
            case (state)
                idle:     if (s1_advance) state <= hold_ack;
                hold_ack: if (ack_take && !s1_advance) state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    assign bank.ack_valid = (state == hold_ack);
    assign bank.ack_hit   = s2_hit;
    assign bank.ack_tag   = s2_fwd_tag;
    assign active         = s1_valid || (state == hold_ack);

endmodule

// File: hdl/snp_forwarder.sv
`timescale 1ns/1ps

module snp_forwarder import snp_cfg_pkg::*, snp_types_pkg::*; (
    input  logic          clk,
    input  logic          reset,

    input  logic          snp_req_valid,
    input  line_addr_t    snp_req_addr,
    input  snp_tag_t      snp_req_tag,
    output logic          snp_req_ready,

    output logic          snp_rsp_valid,
    output line_addr_t    snp_rsp_addr,
    output snp_tag_t      snp_rsp_tag,
    output logic          snp_rsp_hit,
    input  logic          snp_rsp_ready,

    output logic          busy,

    snp_fwd_if.forwarder  banks [num_banks]
);

    // **************************************************
    // pending table
    // **************************************************
    logic [snrq_depth-1:0] slot_busy;
    line_addr_t            slot_addr [snrq_depth];
    snp_tag_t              slot_tag  [snrq_depth];
    ack_cnt_t              slot_cnt  [snrq_depth];
    logic [snrq_depth-1:0] slot_hit;

    fwd_tag_t              alloc_slot;
    logic                  have_free;
    logic                  enqueue;

    // bank side, gathered into plain vectors so they can be indexed
    logic [num_banks-1:0]  fwd_ready_vec;
    logic [num_banks-1:0]  ack_valid_vec;
    logic [num_banks-1:0]  ack_hit_vec;
    fwd_tag_t              ack_tag_vec [num_banks];

    bank_sel_t             rr_sel;
    logic                  sel_valid;
    logic                  sel_hit;
    fwd_tag_t              sel_tag;
    logic                  ack_take;
    logic                  rsp_take;
    logic                  rr_hold;

    // lowest free slot wins
    always_comb begin
        alloc_slot = '0;
        have_free  = 1'b0;
        for (int s = snrq_depth - 1; s >= 0; s--) begin
            if (!slot_busy[s]) begin
                alloc_slot = fwd_tag_t'(s);
                have_free  = 1'b1;
            end
        end
    end

    assign snp_req_ready = have_free && (&fwd_ready_vec);
    assign enqueue       = snp_req_valid && snp_req_ready;
    assign busy          = |slot_busy;

    for (genvar b = 0; b < num_banks; b++) begin : g_bank_io
        assign banks[b].fwd_valid = enqueue;    // all banks or none
        assign banks[b].fwd_addr  = snp_req_addr;
        assign banks[b].fwd_tag   = alloc_slot;
        assign banks[b].ack_ready = snp_rsp_ready && (rr_sel == bank_sel_t'(b));

        assign fwd_ready_vec[b]   = banks[b].fwd_ready;
        assign ack_valid_vec[b]   = banks[b].ack_valid;
        assign ack_hit_vec[b]     = banks[b].ack_hit;
        assign ack_tag_vec[b]     = banks[b].ack_tag;
    end

    // **************************************************
    // round-robin collection
    // **************************************************
    assign sel_valid = ack_valid_vec[rr_sel];
    assign sel_hit   = ack_hit_vec[rr_sel];
    assign sel_tag   = ack_tag_vec[rr_sel];
    assign ack_take  = sel_valid && snp_rsp_ready;

    // the last ack of a slot is offered straight as the response
    assign snp_rsp_valid = sel_valid && (slot_cnt[sel_tag] == ack_cnt_t'(1));
    assign snp_rsp_addr  = slot_addr[sel_tag];
    assign snp_rsp_tag   = slot_tag[sel_tag];
    assign snp_rsp_hit   = slot_hit[sel_tag] || sel_hit;
    assign rsp_take      = snp_rsp_valid && snp_rsp_ready;
    assign rr_hold       = snp_rsp_valid && !snp_rsp_ready;    // an offered response waits on its bank

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_busy <= '0;
            rr_sel    <= '0;
        end else begin
            if (rr_hold) begin
                rr_sel <= rr_sel;
            end else if (rr_sel == bank_sel_t'(num_banks - 1)) begin
                rr_sel <= '0;
            end else begin
                rr_sel <= rr_sel + 1'b1;
            end
            if (rsp_take) begin
                slot_busy[sel_tag] <= 1'b0;    // freed in any order
            end
            if (enqueue) begin
                slot_busy[alloc_slot] <= 1'b1;
            end
        end
    end

    // a newly allocated slot is never the one being collected
    always_ff @(posedge clk) begin
        if (ack_take) begin
            slot_cnt[sel_tag] <= slot_cnt[sel_tag] - 1'b1;
            slot_hit[sel_tag] <= slot_hit[sel_tag] || sel_hit;
        end
        if (enqueue) begin
            slot_addr[alloc_slot] <= snp_req_addr;
            slot_tag[alloc_slot]  <= snp_req_tag;
            slot_cnt[alloc_slot]  <= ack_cnt_t'(num_banks);
            slot_hit[alloc_slot]  <= 1'b0;
        end
    end

endmodule

// File: hdl/snoop_fabric_top.sv
`timescale 1ns/1ps

module snoop_fabric_top import snp_cfg_pkg::*, snp_types_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       snp_req_valid,
    input  line_addr_t snp_req_addr,
    input  snp_tag_t   snp_req_tag,
    output logic       snp_req_ready,

    output logic       snp_rsp_valid,
    output line_addr_t snp_rsp_addr,
    output snp_tag_t   snp_rsp_tag,
    output logic       snp_rsp_hit,
    input  logic       snp_rsp_ready,

    input  logic       fill_valid,
    input  line_addr_t fill_addr,
    output logic       fill_ready
);

    snp_fwd_if fwd_if [num_banks] ();

    logic [num_banks-1:0] bank_active;
    logic [num_banks-1:0] bank_fill;
    logic                 fwd_busy;
    bank_sel_t            fill_bank;

    // fills wait until no snoop is anywhere in the fabric
    assign fill_ready = !(|bank_active) && !fwd_busy && !(snp_req_valid && snp_req_ready);
    assign fill_bank  = fill_addr[bank_bits-1:0];

    snp_forwarder forwarder0 (
        .clk           (clk),
        .reset         (reset),
        .snp_req_valid (snp_req_valid),
        .snp_req_addr  (snp_req_addr),
        .snp_req_tag   (snp_req_tag),
        .snp_req_ready (snp_req_ready),
        .snp_rsp_valid (snp_rsp_valid),
        .snp_rsp_addr  (snp_rsp_addr),
        .snp_rsp_tag   (snp_rsp_tag),
        .snp_rsp_hit   (snp_rsp_hit),
        .snp_rsp_ready (snp_rsp_ready),
        .busy          (fwd_busy),
        .banks         (fwd_if)
    );

    // **************************************************
    // banks
    // **************************************************
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        assign bank_fill[b] = fill_valid && fill_ready && (fill_bank == bank_sel_t'(b));

        snp_bank_tags bank_tags (
            .clk        (clk),
            .reset      (reset),
            .fill_valid (bank_fill[b]),
            .fill_addr  (fill_addr),
            .bank       (fwd_if[b]),
            .active     (bank_active[b])
        );
    end

endmodule

// File: testbench/snoop_fabric_props.sv
`timescale 1ns/1ps

module snoop_fabric_props import snp_cfg_pkg::*, snp_types_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       snp_req_valid,
    input logic       snp_req_ready,
    input logic       snp_rsp_valid,
    input logic       snp_rsp_ready,
    input line_addr_t snp_rsp_addr,
    input snp_tag_t   snp_rsp_tag,
    input logic       snp_rsp_hit,
    input logic       fill_ready,
    input logic       exp_known,     // model holds the response tag as outstanding
    input line_addr_t exp_addr,
    input logic       exp_hit,
    input int         outstanding
);

    int fail_count = 0;

    // **************************************************
    // response checks
    // **************************************************
    rsp_known: assert property (@(posedge clk) disable iff (reset)
        snp_rsp_valid && snp_rsp_ready |-> exp_known)
        else begin fail_count++; $error("response for a tag that is not outstanding"); end

    rsp_match: assert property (@(posedge clk) disable iff (reset)
        snp_rsp_valid && snp_rsp_ready && exp_known
        |-> snp_rsp_addr == exp_addr && snp_rsp_hit == exp_hit)
        else begin fail_count++; $error("response address or hit differs from the model"); end

    // a stalled response keeps its payload
    rsp_stable: assert property (@(posedge clk) disable iff (reset)
        snp_rsp_valid && !snp_rsp_ready |=> snp_rsp_valid && $stable(snp_rsp_addr)
        && $stable(snp_rsp_tag) && $stable(snp_rsp_hit))
        else begin fail_count++; $error("stalled response changed before the transfer"); end

    // **************************************************
    // flow control
    // **************************************************
    req_full: assert property (@(posedge clk) disable iff (reset)
        outstanding >= snrq_depth |-> !snp_req_ready)
        else begin fail_count++; $error("request ready with every slot taken"); end

    fill_stall: assert property (@(posedge clk) disable iff (reset)
        (outstanding != 0 || (snp_req_valid && snp_req_ready)) |-> !fill_ready)
        else begin fail_count++; $error("fill ready while a snoop is in flight"); end

    reset_quiet: assert property (@(posedge clk) reset |=> !snp_rsp_valid)
        else begin fail_count++; $error("response valid straight after reset"); end

endmodule

// File: testbench/snoop_fabric_tb.sv
`timescale 1ns/1ps

module snoop_fabric_tb import snp_cfg_pkg::*, snp_types_pkg::*; ();

    localparam int clk_period     = 4;
    localparam int n_tags         = 2 ** snp_tag_bits;
    localparam int n_reset_snoops = 6;
    localparam int n_directed     = 7;
    localparam int n_fills        = 24;
    localparam int n_snoops       = 60;
    localparam int n_mixed        = 60;
    localparam int total_txn      = n_reset_snoops + n_directed + n_fills + n_snoops + n_mixed;

    logic       clk;
    logic       reset;
    logic       snp_req_valid;
    line_addr_t snp_req_addr;
    snp_tag_t   snp_req_tag;
    logic       snp_req_ready;
    logic       snp_rsp_valid;
    line_addr_t snp_rsp_addr;
    snp_tag_t   snp_rsp_tag;
    logic       snp_rsp_hit;
    logic       snp_rsp_ready;
    logic       fill_valid;
    line_addr_t fill_addr;
    logic       fill_ready;
    logic       stall_on;

    // reference model, one tag store per bank like the DUT
    logic [lines_per_bank-1:0] model_valid [num_banks];
    logic [tag_bits-1:0]       model_tag   [num_banks][lines_per_bank];
    logic [n_tags-1:0]         pend_mask;
    logic [n_tags-1:0]         pend_hit;
    line_addr_t                pend_addr [n_tags];
    int                        outstanding;
    logic                      exp_known;
    logic                      exp_hit;
    line_addr_t                exp_addr;

    snoop_fabric_top dut0 (.*);

    bind snoop_fabric_top snoop_fabric_props props0 (
        .clk (clk), .reset (reset),
        .snp_req_valid (snp_req_valid), .snp_req_ready (snp_req_ready),
        .snp_rsp_valid (snp_rsp_valid), .snp_rsp_ready (snp_rsp_ready),
        .snp_rsp_addr (snp_rsp_addr), .snp_rsp_tag (snp_rsp_tag),
        .snp_rsp_hit (snp_rsp_hit), .fill_ready (fill_ready),
        .exp_known (snoop_fabric_tb.exp_known), .exp_addr (snoop_fabric_tb.exp_addr),
        .exp_hit (snoop_fabric_tb.exp_hit), .outstanding (snoop_fabric_tb.outstanding)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    assign exp_known = pend_mask[snp_rsp_tag];
    assign exp_hit   = pend_hit[snp_rsp_tag];
    assign exp_addr  = pend_addr[snp_rsp_tag];

    // **************************************************
    // model update on accepted transfers
    // **************************************************
    always @(posedge clk) begin
        logic                  hit;
        logic                  req_acc;
        logic                  rsp_acc;
        logic [index_bits-1:0] idx;
        req_acc = snp_req_valid && snp_req_ready;
        rsp_acc = snp_rsp_valid && snp_rsp_ready;
        if (reset) begin
            for (int b = 0; b < num_banks; b++) model_valid[b] <= '0;
            pend_mask   <= '0;
            outstanding <= 0;
        end else begin
            if (fill_valid && fill_ready) begin
                idx = fill_addr[bank_bits +: index_bits];
                model_valid[fill_addr[bank_bits-1:0]][idx] <= 1'b1;
                model_tag[fill_addr[bank_bits-1:0]][idx]   <= fill_addr[line_addr_bits-1 -: tag_bits];
            end
            if (req_acc) begin
                idx = snp_req_addr[bank_bits +: index_bits];
                hit = 1'b0;
                // every bank sees the snoop, bank bits play no part in the lookup
                for (int b = 0; b < num_banks; b++) begin
                    if (model_valid[b][idx]
                        && model_tag[b][idx] == snp_req_addr[line_addr_bits-1 -: tag_bits]) begin
                        hit = 1'b1;
                        model_valid[b][idx] <= 1'b0;
                    end
                end
                pend_mask[snp_req_tag] <= 1'b1;
                pend_hit[snp_req_tag]  <= hit;
                pend_addr[snp_req_tag] <= snp_req_addr;
            end
            if (rsp_acc) pend_mask[snp_rsp_tag] <= 1'b0;
            outstanding <= outstanding + int'(req_acc) - int'(rsp_acc);
        end
    end

    function automatic line_addr_t make_addr(input int t, input int idx, input int b);
        line_addr_t a;
        a = '0;
        a[line_addr_bits-1 -: tag_bits] = t[tag_bits-1:0];
        a[bank_bits +: index_bits]      = idx[index_bits-1:0];
        a[bank_bits-1:0]                = b[bank_bits-1:0];
        return a;
    endfunction

    // small pool, so hits, misses and index conflicts all show up
    function automatic line_addr_t rand_addr();
        return make_addr($urandom_range(3), $urandom_range(3), $urandom_range(num_banks - 1));
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        snp_rsp_ready = stall_on ? ($urandom_range(1) == 1) : 1'b1;
    endtask

    task automatic do_fill(input line_addr_t a);
        logic took;
        fill_valid = 1'b1;
        fill_addr  = a;
        do begin
            #1 took = fill_ready;    // read mid-cycle, before the edge that transfers
            next_cycle();
        end while (!took);
        fill_valid = 1'b0;
    endtask

    task automatic do_snoop(input line_addr_t a);
        snp_tag_t t;
        logic     took;
        t = snp_tag_t'($urandom);
        while (pend_mask[t]) t = t + 1'b1;
        snp_req_valid = 1'b1;
        snp_req_addr  = a;
        snp_req_tag   = t;
        do begin
            #1 took = snp_req_ready;
            next_cycle();
        end while (!took);
        snp_req_valid = 1'b0;
    endtask

    // **************************************************
    // stimulus
    // **************************************************
    initial begin
        void'($urandom(87726));
        reset         = 1'b1;
        stall_on      = 1'b0;
        snp_req_valid = 1'b0;
        snp_req_addr  = '0;
        snp_req_tag   = '0;
        snp_rsp_ready = 1'b1;
        fill_valid    = 1'b0;
        fill_addr     = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        repeat (n_reset_snoops) do_snoop(rand_addr());    // nothing filled yet

        // hit, then miss, then a conflicting fill pushes the line out
        do_fill(make_addr(5, 7, 1));
        do_snoop(make_addr(5, 7, 1));
        do_snoop(make_addr(5, 7, 1));
        do_fill(make_addr(5, 7, 1));
        do_fill(make_addr(6, 7, 1));
        do_snoop(make_addr(5, 7, 1));
        do_snoop(make_addr(6, 7, 1));

        repeat (n_fills) do_fill(rand_addr());
        stall_on = 1'b1;
        repeat (n_snoops) do_snoop(rand_addr());
        repeat (n_mixed) begin
            if ($urandom_range(2) == 0) do_fill(rand_addr());
            else do_snoop(rand_addr());
        end
        stall_on = 1'b0;
        while (outstanding != 0) next_cycle();
        repeat (2) next_cycle();

        if (dut0.props0.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERR %0t: %0d assertion failures", $time, dut0.props0.fail_count);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped on assertion failures");
        end
    end

    initial begin
        wait (dut0.props0.fail_count != 0);
        $display("ERR %0t: assertion failed in snoop_fabric_props", $time);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first assertion failure");
    end

    initial begin
        #(total_txn * 40 * clk_period);
        $display("timeout: the snoop and fill traffic did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: snoop_fabric.f
hdl/snp_cfg_pkg.sv
hdl/snp_types_pkg.sv
hdl/snp_fwd_if.sv
hdl/snp_bank_tags.sv
hdl/snp_forwarder.sv
hdl/snoop_fabric_top.sv
testbench/snoop_fabric_props.sv
testbench/snoop_fabric_tb.sv
